//--- logic/bus_pkg.sv
package bus_pkg;

	// ----------------------------------------------
	// register bus widths
	// ----------------------------------------------

	parameter int unsigned ADDR_W = 32;
	parameter int unsigned DATA_W = 32;
	parameter int unsigned SEL_W  = DATA_W / 8;	// one enable per byte lane

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] word_t;
	typedef logic [SEL_W-1:0]  sel_t;

endpackage

//--- logic/io_map_pkg.sv
package io_map_pkg;

	// ----------------------------------------------
	// upper address tags of the on-chip targets
	// ----------------------------------------------

	parameter logic [11:0] SCR_BASE  = 12'h001;	// 0x001x_xxxx
	parameter logic [15:0] SEMA_BASE = 16'hFD05;	// 0xFD05_xxxx
	parameter logic [23:0] LED_BASE  = 24'hFD0FFF;	// 0xFD0F_FFxx
	parameter logic [23:0] RAND_BASE = 24'hFD0FFD;	// 0xFD0F_FDxx

	// set means plain read, clear means read with decrement
	parameter int unsigned SEMA_PEEK_BIT = 13;

	// decoded target of one bus request
	typedef enum logic [2:0] {
		REGION_NONE,
		REGION_SCR,
		REGION_SEMA,
		REGION_LED,
		REGION_RAND
	} region_e;

endpackage

//--- logic/bus_decode.sv
`timescale 1ns/10ps

module bus_decode (
	input  logic           cyc_i,
	input  logic           stb_i,
	input  bus_pkg::addr_t adr_i,
	output logic           scr_stb_o,
	output logic           sema_stb_o,
	output logic           led_stb_o,
	output logic           rand_stb_o
);

	io_map_pkg::region_e region;
	logic                req;

	assign req = cyc_i & stb_i;

	// tag compare against the address map
	always_comb begin
		if (adr_i[31:20] == io_map_pkg::SCR_BASE)
			region = io_map_pkg::REGION_SCR;
		else if (adr_i[31:16] == io_map_pkg::SEMA_BASE)
			region = io_map_pkg::REGION_SEMA;
		else if (adr_i[31:8] == io_map_pkg::LED_BASE)
			region = io_map_pkg::REGION_LED;
		else if (adr_i[31:8] == io_map_pkg::RAND_BASE)
			region = io_map_pkg::REGION_RAND;
		else
			region = io_map_pkg::REGION_NONE;	// never acked
	end

	// one strobe per region, none for an unmapped address
	always_comb begin
		scr_stb_o  = 1'b0;
		sema_stb_o = 1'b0;
		led_stb_o  = 1'b0;
		rand_stb_o = 1'b0;
		case (region)
			io_map_pkg::REGION_SCR:  scr_stb_o  = req;
			io_map_pkg::REGION_SEMA: sema_stb_o = req;
			io_map_pkg::REGION_LED:  led_stb_o  = req;
			io_map_pkg::REGION_RAND: rand_stb_o = req;
			default: ;
		endcase
	end

endmodule

//--- logic/scratch_ram.sv
`timescale 1ns/10ps

module scratch_ram #(
	parameter int unsigned SCR_AW = 12
) (
	input  logic              node_clk,
	input  logic              rst,
	input  logic              stb_i,
	input  logic              we_i,
	input  bus_pkg::sel_t     sel_i,
	input  logic [SCR_AW-1:0] adr_i,
	input  bus_pkg::word_t    dat_i,
	output logic              ack_o,
	output bus_pkg::word_t    dat_o
);

	localparam int unsigned DEPTH = 2 ** SCR_AW;

	bus_pkg::word_t mem [DEPTH];
	bus_pkg::word_t rd_q;
	logic           busy_q;
	logic           ack_q;
	logic           go;

	assign go = stb_i & ~busy_q;	// first cycle of a request only

	always_ff @(posedge node_clk) begin
		if (rst) begin
			busy_q <= 1'b0;
			ack_q  <= 1'b0;
		end else begin
			busy_q <= stb_i;	// drops once the strobe goes away
			ack_q  <= go;
		end
	end

	// byte lane writes
	always_ff @(posedge node_clk) begin
		if (go & we_i) begin
			for (int b = 0; b < bus_pkg::SEL_W; b++) begin
				if (sel_i[b])
					mem[adr_i][b*8 +: 8] <= dat_i[b*8 +: 8];
			end
		end
	end

	always_ff @(posedge node_clk)
		rd_q <= mem[adr_i];	// registered read port

	assign ack_o = ack_q;
	assign dat_o = ack_q ? rd_q : '0;

endmodule

//--- logic/sema_ram.sv
`timescale 1ns/10ps

module sema_ram #(
	parameter int unsigned SEMA_AW = 10
) (
	input  logic               node_clk,
	input  logic               rst,
	input  logic               stb_i,
	input  logic               we_i,
	input  logic [SEMA_AW-1:0] adr_i,
	input  logic               peek_i,
	input  logic [7:0]         dat_i,
	output logic               ack_o,
	output bus_pkg::word_t     dat_o
);

	localparam int unsigned NSEMA = 2 ** SEMA_AW;

	logic [7:0]     sema_q [NSEMA];
	logic [7:0]     cur;
	bus_pkg::word_t dat_q;
	logic           busy_q;
	logic           ack_q;
	logic           go;

	assign go  = stb_i & ~busy_q;
	assign cur = sema_q[adr_i];	// value before the operation

	always_ff @(posedge node_clk) begin
		if (rst) begin
			for (int i = 0; i < NSEMA; i++)
				sema_q[i] <= 8'h00;
			busy_q <= 1'b0;
			ack_q  <= 1'b0;
			dat_q  <= '0;
		end else begin
			busy_q <= stb_i;
			ack_q  <= go;
			dat_q  <= '0;
			if (go) begin
				if (we_i) begin
					sema_q[adr_i] <= dat_i;
				end else begin
					dat_q <= {bus_pkg::SEL_W{cur}};	// same count in every byte
					if (!peek_i && cur != 8'h00)
						sema_q[adr_i] <= cur - 8'd1;	// take one
				end
			end
		end
	end

	assign ack_o = ack_q;
	assign dat_o = dat_q;

endmodule

//--- logic/sys_regs.sv
`timescale 1ns/10ps

module sys_regs #(
	parameter bus_pkg::word_t RAND_SEED = 32'h1234_5678
) (
	input  logic           node_clk,
	input  logic           rst,
	input  logic           led_stb_i,
	input  logic           rand_stb_i,
	input  logic           we_i,
	input  bus_pkg::word_t dat_i,
	output logic           ack_o,
	output bus_pkg::word_t dat_o,
	output logic [7:0]     led_o
);

	localparam bus_pkg::word_t LFSR_POLY = 32'h8020_0003;

	logic [7:0]     led_q;
	bus_pkg::word_t lfsr_q;
	bus_pkg::word_t lfsr_next;
	bus_pkg::word_t dat_q;
	logic           busy_q;
	logic           ack_q;
	logic           go;

	assign go = (led_stb_i | rand_stb_i) & ~busy_q;

	// galois step, right shift
	assign lfsr_next = {1'b0, lfsr_q[31:1]} ^ (lfsr_q[0] ? LFSR_POLY : '0);

	// ----------------------------------------------
	// led and random registers
	// ----------------------------------------------

	always_ff @(posedge node_clk) begin
		if (rst) begin
			led_q  <= 8'h00;
			lfsr_q <= RAND_SEED;
			busy_q <= 1'b0;
			ack_q  <= 1'b0;
			dat_q  <= '0;
		end else begin
			busy_q <= led_stb_i | rand_stb_i;
			ack_q  <= go;
			dat_q  <= '0;
			if (go && led_stb_i) begin
				if (we_i)
					led_q <= dat_i[7:0];
				else
					dat_q <= {24'h000000, led_q};
			end
			if (go && rand_stb_i) begin
				if (we_i) begin
					lfsr_q <= (dat_i == '0) ? RAND_SEED : dat_i;	// zero would lock up
				end else begin
					dat_q  <= lfsr_q;
					lfsr_q <= lfsr_next;	// one step per read
				end
			end
		end
	end

	assign ack_o = ack_q;
	assign dat_o = dat_q;
	assign led_o = led_q;

endmodule

//--- logic/resp_merge.sv
`timescale 1ns/10ps

module resp_merge (
	input  logic           node_clk,
	input  logic           rst,
	input  logic           ack0_i,
	input  logic           ack1_i,
	input  logic           ack2_i,
	input  logic           ack3_i,
	input  bus_pkg::word_t dat0_i,
	input  bus_pkg::word_t dat1_i,
	input  bus_pkg::word_t dat2_i,
	input  bus_pkg::word_t dat3_i,
	output logic           ack_o,
	output bus_pkg::word_t dat_o
);

	// idle targets drive zero, so a plain OR selects the responder
	always_ff @(posedge node_clk) begin
		if (rst) begin
			ack_o <= 1'b0;
			dat_o <= '0;
		end else begin
			ack_o <= ack0_i | ack1_i | ack2_i | ack3_i;
			dat_o <= dat0_i | dat1_i | dat2_i | dat3_i;
		end
	end

endmodule

//--- logic/io_fabric.sv
`timescale 1ns/10ps

module io_fabric #(
	parameter int unsigned   SCR_AW    = 12,
	parameter int unsigned   SEMA_AW   = 10,
	parameter bus_pkg::word_t RAND_SEED = 32'h1234_5678
) (
	input  logic           node_clk,
	input  logic           rst,
	input  logic           cyc_i,
	input  logic           stb_i,
	input  logic           we_i,
	input  bus_pkg::sel_t  sel_i,
	input  bus_pkg::addr_t adr_i,
	input  bus_pkg::word_t dat_i,
	output logic           ack_o,
	output bus_pkg::word_t dat_o,
	output logic [7:0]     led_o
);

	logic scr_stb;
	logic sema_stb;
	logic led_stb;
	logic rand_stb;

	logic scr_ack;
	logic sema_ack;
	logic sys_ack;
	bus_pkg::word_t scr_dat;
	bus_pkg::word_t sema_dat;
	bus_pkg::word_t sys_dat;

	// ----------------------------------------------
	// address decode
	// ----------------------------------------------

	bus_decode u_bus_decode (
		.cyc_i      (cyc_i),
		.stb_i      (stb_i),
		.adr_i      (adr_i),
		.scr_stb_o  (scr_stb),
		.sema_stb_o (sema_stb),
		.led_stb_o  (led_stb),
		.rand_stb_o (rand_stb)
	);

	// ----------------------------------------------
	// targets
	// ----------------------------------------------

	scratch_ram #(.SCR_AW(SCR_AW)) u_scratch_ram (
		.node_clk (node_clk),
		.rst      (rst),
		.stb_i    (scr_stb),
		.we_i     (we_i),
		.sel_i    (sel_i),
		.adr_i    (adr_i[SCR_AW+1:2]),	// word address
		.dat_i    (dat_i),
		.ack_o    (scr_ack),
		.dat_o    (scr_dat)
	);

	sema_ram #(.SEMA_AW(SEMA_AW)) u_sema_ram (
		.node_clk (node_clk),
		.rst      (rst),
		.stb_i    (sema_stb),
		.we_i     (we_i),
		.adr_i    (adr_i[SEMA_AW+1:2]),
		.peek_i   (adr_i[io_map_pkg::SEMA_PEEK_BIT]),
		.dat_i    (dat_i[7:0]),
		.ack_o    (sema_ack),
		.dat_o    (sema_dat)
	);

	sys_regs #(.RAND_SEED(RAND_SEED)) u_sys_regs (
		.node_clk   (node_clk),
		.rst        (rst),
		.led_stb_i  (led_stb),
		.rand_stb_i (rand_stb),
		.we_i       (we_i),
		.dat_i      (dat_i),
		.ack_o      (sys_ack),
		.dat_o      (sys_dat),
		.led_o      (led_o)
	);

	// fourth slot is free for a later target
	resp_merge u_resp_merge (
		.node_clk (node_clk),
		.rst      (rst),
		.ack0_i   (scr_ack),
		.ack1_i   (sema_ack),
		.ack2_i   (sys_ack),
		.ack3_i   (1'b0),
		.dat0_i   (scr_dat),
		.dat1_i   (sema_dat),
		.dat2_i   (sys_dat),
		.dat3_i   ('0),
		.ack_o    (ack_o),
		.dat_o    (dat_o)
	);

endmodule

//--- testbench/tb_bus_tasks.svh
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// address map as the bus master sees it
function automatic io_map_pkg::region_e region_of(input bus_pkg::addr_t addr);
	if (addr[31:20] == io_map_pkg::SCR_BASE)
		return io_map_pkg::REGION_SCR;
	if (addr[31:16] == io_map_pkg::SEMA_BASE)
		return io_map_pkg::REGION_SEMA;
	if (addr[31:8] == io_map_pkg::LED_BASE)
		return io_map_pkg::REGION_LED;
	if (addr[31:8] == io_map_pkg::RAND_BASE)
		return io_map_pkg::REGION_RAND;
	return io_map_pkg::REGION_NONE;
endfunction

// byte lane model of a partial write
function automatic bus_pkg::word_t merge_lanes(input bus_pkg::word_t old_w,
		input bus_pkg::word_t new_w, input bus_pkg::sel_t lanes);
	bus_pkg::word_t res;
	res = old_w;
	for (int b = 0; b < bus_pkg::SEL_W; b++) begin
		if (lanes[b])
			res[b*8 +: 8] = new_w[b*8 +: 8];
	end
	return res;
endfunction

// galois right shift, poly 0x8020_0003
function automatic bus_pkg::word_t lfsr_step(input bus_pkg::word_t v);
	if (v[0])
		return (v >> 1) ^ 32'h8020_0003;
	return v >> 1;
endfunction

task automatic check_word(input string name, input bus_pkg::word_t got,
		input bus_pkg::word_t exp);
	check_cnt++;
	assert (got === exp) else begin
		$display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
		err_cnt++;
	end
endtask

// one request, held until ack_o or max_cyc cycles
task automatic bus_access(input bus_pkg::addr_t addr, input logic wr,
		input bus_pkg::sel_t lanes, input bus_pkg::word_t wd, input int max_cyc,
		output bus_pkg::word_t rd, output bit acked, output int lat);
	int n;
	cyc = 1'b1;
	stb = 1'b1;
	we = wr;
	sel = lanes;
	adr = addr;
	wdat = wd;
	expect_ack = (region_of(addr) != io_map_pkg::REGION_NONE);
	acked = 1'b0;
	rd = '0;
	n = 0;
	while (!acked && n < max_cyc) begin
		@(negedge node_clk);
		n++;
		if (ack) begin
			acked = 1'b1;
			rd = rdat;
		end
	end
	lat = n;
	cyc = 1'b0;
	stb = 1'b0;
	we = 1'b0;
	@(negedge node_clk);	// idle cycle before the next request
endtask

task automatic bus_write(input bus_pkg::addr_t addr, input bus_pkg::word_t wd,
		input bus_pkg::sel_t lanes);
	bus_pkg::word_t unused;
	bit acked;
	bus_access(addr, 1'b1, lanes, wd, BUS_TIMEOUT, unused, acked, last_lat);
	if (!acked) begin
		$display("no ack_o within %0d cycles for a write to 0x%08h", BUS_TIMEOUT, addr);
		err_cnt++;
	end
endtask

task automatic bus_read(input bus_pkg::addr_t addr, output bus_pkg::word_t rd);
	bit acked;
	bus_access(addr, 1'b0, 4'hF, '0, BUS_TIMEOUT, rd, acked, last_lat);
	if (!acked) begin
		$display("no ack_o within %0d cycles for a read from 0x%08h", BUS_TIMEOUT, addr);
		err_cnt++;
	end
endtask

`endif

//--- testbench/tb_io_fabric.sv
`timescale 1ns/10ps

module tb_io_fabric;

	localparam bus_pkg::word_t RAND_SEED = 32'h1234_5678;
	localparam bus_pkg::addr_t SCR_ADR   = {io_map_pkg::SCR_BASE, 20'h0_0000};
	localparam bus_pkg::addr_t SEMA_ADR  = {io_map_pkg::SEMA_BASE, 16'h0000};
	localparam bus_pkg::addr_t LED_ADR   = {io_map_pkg::LED_BASE, 8'h00};
	localparam bus_pkg::addr_t RAND_ADR  = {io_map_pkg::RAND_BASE, 8'h00};
	localparam bus_pkg::addr_t PEEK      = 32'h1 << io_map_pkg::SEMA_PEEK_BIT;
	localparam int BUS_TIMEOUT = 16;

	logic           node_clk;
	logic           rst;
	logic           cyc;
	logic           stb;
	logic           we;
	bus_pkg::sel_t  sel;
	bus_pkg::addr_t adr;
	bus_pkg::word_t wdat;
	logic           ack;
	bus_pkg::word_t rdat;
	logic [7:0]     led;
	logic           stb_d;
	logic           stb_rise;
	logic           expect_ack;	// request goes to a mapped target
	int             err_cnt;
	int             check_cnt;
	int             test_cnt;
	int             test_err_base;
	int             last_lat;

	`include "tb_bus_tasks.svh"

	io_fabric #(.RAND_SEED(RAND_SEED)) u_io_fabric (
		.node_clk (node_clk),
		.rst      (rst),
		.cyc_i    (cyc),
		.stb_i    (stb),
		.we_i     (we),
		.sel_i    (sel),
		.adr_i    (adr),
		.dat_i    (wdat),
		.ack_o    (ack),
		.dat_o    (rdat),
		.led_o    (led)
	);

	always #4 node_clk = ~node_clk;

	always_ff @(posedge node_clk)
		stb_d <= rst ? 1'b0 : stb;
	assign stb_rise = stb & ~stb_d;

	// --------------------------------------------------
	// ack_o width and fixed two cycle latency
	// --------------------------------------------------

	assert property (@(posedge node_clk) disable iff (rst) ack |=> !ack) else begin
		$display("ack_o stayed high for more than one cycle");
		err_cnt++;
	end

	assert property (@(posedge node_clk) disable iff (rst)
			(stb_rise && expect_ack) |-> ##2 ack) else begin
		$display("ack_o did not arrive two cycles after the strobe");
		err_cnt++;
	end

	assert property (@(posedge node_clk) disable iff (rst)
			ack |-> $past(stb_rise && expect_ack, 2)) else begin
		$display("ack_o rose without a mapped strobe two cycles before");
		err_cnt++;
	end

	task automatic report_test(input string name);
		test_cnt++;
		$display("test %s finished with %0d errors", name, err_cnt - test_err_base);
		test_err_base = err_cnt;
	endtask

	initial begin
		bus_pkg::word_t d;
		bus_pkg::word_t w;
		bus_pkg::word_t exp;
		bus_pkg::addr_t a;
		bus_pkg::sel_t  s;
		bus_pkg::addr_t scr_list [$];
		bus_pkg::word_t scr_model [bus_pkg::addr_t];
		bit             acked;

		void'($urandom(32'h4e4a_461e));
		node_clk = 1'b0;
		rst = 1'b1;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		sel = '0;
		adr = '0;
		wdat = '0;
		expect_ack = 1'b0;
		err_cnt = 0;
		check_cnt = 0;
		test_cnt = 0;
		test_err_base = 0;
		last_lat = 0;
		repeat (16) @(posedge node_clk);
		@(negedge node_clk);
		rst = 1'b0;
		check_word("ack_o", ack, 0);	// reset state
		check_word("dat_o", rdat, 0);
		check_word("led_o", led, 0);

		// scratch ram full words then random byte lanes
		for (int i = 0; i < 8; i++) begin
			a = SCR_ADR | (($urandom % 4096) << 2);
			d = $urandom;
			bus_write(a, d, 4'hF);
			scr_model[a] = d;
			scr_list.push_back(a);
		end
		foreach (scr_list[i]) begin
			bus_read(scr_list[i], d);
			check_word($sformatf("dat_o @ %08h", scr_list[i]), d, scr_model[scr_list[i]]);
		end
		foreach (scr_list[i]) begin
			s = bus_pkg::sel_t'($urandom);
			w = $urandom;
			bus_write(scr_list[i], w, s);
			scr_model[scr_list[i]] = merge_lanes(scr_model[scr_list[i]], w, s);
			bus_read(scr_list[i], d);
			check_word($sformatf("dat_o @ %08h", scr_list[i]), d, scr_model[scr_list[i]]);
		end
		report_test("scratch_ram");

		// semaphores 5 and 9
		bus_write(SEMA_ADR + 32'h14, 32'h0000_0003, 4'hF);
		w = $urandom;
		bus_write(SEMA_ADR + 32'h24, {w[31:8], 8'h55}, 4'hF);	// low byte counts
		for (int n = 3; n >= 0; n--) begin
			bus_read(SEMA_ADR + 32'h14, d);
			check_word("dat_o sema 5", d, {4{8'(n)}});
		end
		bus_read(SEMA_ADR + PEEK + 32'h14, d);
		check_word("dat_o sema 5 peek", d, 0);
		bus_read(SEMA_ADR + 32'h14, d);
		check_word("dat_o sema 5", d, 0);	// stays at zero
		repeat (2) begin
			bus_read(SEMA_ADR + PEEK + 32'h24, d);
			check_word("dat_o sema 9 peek", d, 32'h5555_5555);
		end
		report_test("sema_ram");

		// led register
		w = $urandom;
		bus_write(LED_ADR, w, 4'hF);
		check_word("led_o", led, w[7:0]);
		bus_read(LED_ADR, d);
		check_word("dat_o led", d, {24'h00_0000, w[7:0]});
		report_test("led");

		// random generator from reset, from a written seed, from zero
		exp = RAND_SEED;
		repeat (4) begin
			bus_read(RAND_ADR, d);
			check_word("dat_o rand", d, exp);
			exp = lfsr_step(exp);
		end
		bus_write(RAND_ADR, 32'hCAFE_F00D, 4'hF);
		exp = 32'hCAFE_F00D;
		repeat (3) begin
			bus_read(RAND_ADR, d);
			check_word("dat_o rand", d, exp);
			exp = lfsr_step(exp);
		end
		bus_write(RAND_ADR, 32'h0000_0000, 4'hF);
		exp = RAND_SEED;
		repeat (2) begin
			bus_read(RAND_ADR, d);
			check_word("dat_o rand", d, exp);
			exp = lfsr_step(exp);
		end
		report_test("rand");

		// --------------------------------------------------
		// bus timing, one effect per request, unmapped
		// --------------------------------------------------
		bus_write(SEMA_ADR + 32'h40, 32'h0000_0005, 4'hF);
		check_word("ack_o latency", last_lat, 2);
		bus_read(SEMA_ADR + 32'h40, d);
		check_word("ack_o latency", last_lat, 2);
		check_word("dat_o sema 16", d, 32'h0505_0505);
		bus_read(SEMA_ADR + PEEK + 32'h40, d);
		check_word("dat_o sema 16 peek", d, 32'h0404_0404);	// single decrement
		bus_access(32'hFD0E_0000, 1'b0, 4'hF, '0, 8, d, acked, last_lat);
		check_cnt++;
		assert (!acked) else begin
			$display("unmapped address 0xfd0e0000 was acknowledged within 8 cycles");
			err_cnt++;
		end
		report_test("bus_timing");

		$display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

//--- sources.f
+incdir+testbench
logic/bus_pkg.sv
logic/io_map_pkg.sv
logic/bus_decode.sv
logic/scratch_ram.sv
logic/sema_ram.sv
logic/sys_regs.sv
logic/resp_merge.sv
logic/io_fabric.sv
testbench/tb_io_fabric.sv

//--- Bender.yml
package:
  name: io_fabric

sources:
  - logic/bus_pkg.sv
  - logic/io_map_pkg.sv
  - logic/bus_decode.sv
  - logic/scratch_ram.sv
  - logic/sema_ram.sv
  - logic/sys_regs.sv
  - logic/resp_merge.sv
  - logic/io_fabric.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_io_fabric.sv
